// ==== logic/cpu_pkg.sv ====
// Shared widths, opcodes, ALU codes, controller states and mux selects for the 8-bit core
package cpu_pkg;

   // Fixed by the instruction encoding
   localparam int data_width  = 8;
   localparam int regbits     = 3;
   localparam int instr_width = 32;

   // Cycles the memory waits before answering a request
   localparam int mem_wait = 2;

   typedef enum logic [5:0] {
      op_rtype = 6'b000000,
      op_j     = 6'b000010,
      op_beq   = 6'b000100,
      op_addi  = 6'b001000,
      op_lb    = 6'b100000,
      op_sb    = 6'b101000,
      op_halt  = 6'b111111
   } opcode_t;

   // R-type function field
   localparam logic [5:0] funct_add = 6'b100000;
   localparam logic [5:0] funct_sub = 6'b100010;
   localparam logic [5:0] funct_and = 6'b100100;
   localparam logic [5:0] funct_or  = 6'b100101;
   localparam logic [5:0] funct_slt = 6'b101010;

   typedef enum logic [2:0] {
      alu_and = 3'b000,
      alu_or  = 3'b001,
      alu_add = 3'b010,
      alu_sub = 3'b110,
      alu_slt = 3'b111
   } alu_op_t;

   typedef enum logic [3:0] {
      fetch1, fetch2, fetch3, fetch4,
      decode, memadr, memrd, memwb, memwr,
      rtype_ex, rtype_wb, addi_wb, beq_ex, j_ex, halt_st
   } ctrl_state_t;

   // Next pc source
   localparam logic [1:0] pc_from_alu    = 2'd0;
   localparam logic [1:0] pc_from_aluout = 2'd1;
   localparam logic [1:0] pc_from_jump   = 2'd2;

   // ALU operand b source
   localparam logic [1:0] src_b_reg  = 2'd0;
   localparam logic [1:0] src_b_one  = 2'd1;
   localparam logic [1:0] src_b_imm  = 2'd2;
   localparam logic [1:0] src_b_imm4 = 2'd3;

endpackage

// ==== logic/mem_bus_if.sv ====
// Four-phase req/ack memory bus between the core and the byte memory
`timescale 1ns/1ps

interface mem_bus_if;
   import cpu_pkg::*;

   logic                  req;
   logic                  ack;
   logic                  we;
   logic [data_width-1:0] adr;
   logic [data_width-1:0] wdata;
   // Valid while ack is high on a read
   logic [data_width-1:0] rdata;

   modport core (output req, we, adr, wdata, input ack, rdata);
   modport mem  (input req, we, adr, wdata, output ack, rdata);

endinterface

// ==== logic/alu.sv ====
// Combinational ALU with zero flag, used by the datapath for all arithmetic
`timescale 1ns/1ps

module alu (
   input  logic [cpu_pkg::data_width-1:0] a,
   input  logic [cpu_pkg::data_width-1:0] b,
   input  cpu_pkg::alu_op_t               alucont,
   output logic [cpu_pkg::data_width-1:0] result,
   output logic                           zero
);
   import cpu_pkg::*;

   logic [data_width-1:0] sum;
   logic [data_width-1:0] diff;
   logic                  less;

   assign sum  = a + b;
   assign diff = a - b;
   // Signed compare, immune to wrap in the subtraction
   assign less = $signed(a) < $signed(b);

   always_comb begin
      case (alucont)
         alu_and: result = a & b;
         alu_or:  result = a | b;
         alu_sub: result = diff;
         alu_slt: result = {{(data_width-1){1'b0}}, less};
         default: result = sum;
      endcase
   end

   assign zero = (result == '0);

endmodule

// ==== logic/regfile.sv ====
// Eight-entry register file, two read ports and one write port, register 0 fixed at zero
`timescale 1ns/1ps

module regfile (
   input  logic                           clk,
   input  logic                           regwrite,
   input  logic [cpu_pkg::regbits-1:0]    ra1,
   input  logic [cpu_pkg::regbits-1:0]    ra2,
   input  logic [cpu_pkg::regbits-1:0]    wa,
   input  logic [cpu_pkg::data_width-1:0] wd,
   output logic [cpu_pkg::data_width-1:0] rd1,
   output logic [cpu_pkg::data_width-1:0] rd2
);
   import cpu_pkg::*;

   logic [data_width-1:0] regs [1 << regbits];

   // Writes to register 0 are dropped
   always_ff @(posedge clk) begin
      if (regwrite && wa != '0) begin
         regs[wa] <= wd;
      end
   end

   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== logic/datapath.sv ====
// Multicycle datapath with pc, instruction bytes, operand registers, regfile and ALU
`timescale 1ns/1ps

module datapath (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           iord,
   input  logic                           alusrca,
   input  logic [1:0]                     alusrcb,
   input  logic [1:0]                     pcsource,
   input  logic                           memtoreg,
   input  logic                           regdst,
   input  logic [3:0]                     irwrite,
   input  logic                           pcen,
   input  logic                           regwrite,
   input  cpu_pkg::alu_op_t               alucont,
   mem_bus_if.core                        bus,
   output cpu_pkg::opcode_t               opcode,
   output logic [5:0]                     funct,
   output logic                           zero
);
   import cpu_pkg::*;

   logic [instr_width-1:0] instr;
   logic [data_width-1:0]  pc;
   logic [data_width-1:0]  next_pc;
   logic [data_width-1:0]  md;
   logic [data_width-1:0]  a;
   logic [data_width-1:0]  b;
   logic [data_width-1:0]  aluout;
   logic [data_width-1:0]  alu_result;
   logic [data_width-1:0]  src_a;
   logic [data_width-1:0]  src_b;
   logic [data_width-1:0]  rd1;
   logic [data_width-1:0]  rd2;
   logic [data_width-1:0]  wd;
   logic [data_width-1:0]  const_x4;
   logic [regbits-1:0]     wa;

   // Instruction assembled one byte per fetch
   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (irwrite[i]) begin
            instr[i*data_width +: data_width] <= bus.rdata;
         end
      end
   end

   assign opcode = opcode_t'(instr[31:26]);
   assign funct  = instr[5:0];

   // Branch offset and jump target share the shifted low byte
   assign const_x4 = {instr[data_width-3:0], 2'b00};

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (pcen) begin
         pc <= next_pc;
      end
   end

   // Loaded every cycle; the controller keeps their sources steady when it matters
   always_ff @(posedge clk) begin
      md     <= bus.rdata;
      a      <= rd1;
      b      <= rd2;
      aluout <= alu_result;
   end

   assign bus.adr   = iord ? aluout : pc;
   assign bus.wdata = b;

   assign wa    = regdst ? instr[11 +: regbits] : instr[16 +: regbits];
   assign wd    = memtoreg ? md : aluout;
   assign src_a = alusrca ? a : pc;

   always_comb begin
      case (alusrcb)
         src_b_reg:  src_b = b;
         src_b_one:  src_b = {{(data_width-1){1'b0}}, 1'b1};
         src_b_imm:  src_b = instr[data_width-1:0];
         default:    src_b = const_x4;
      endcase
   end

   always_comb begin
      case (pcsource)
         pc_from_aluout: next_pc = aluout;
         pc_from_jump:   next_pc = const_x4;
         default:        next_pc = alu_result;
      endcase
   end

   regfile regfile_inst (
      .clk      (clk),
      .regwrite (regwrite),
      .ra1      (instr[21 +: regbits]),
      .ra2      (instr[16 +: regbits]),
      .wa       (wa),
      .wd       (wd),
      .rd1      (rd1),
      .rd2      (rd2)
   );

   alu alu_inst (
      .a       (src_a),
      .b       (src_b),
      .alucont (alucont),
      .result  (alu_result),
      .zero    (zero)
   );

   // Write-back never overlaps fetch or a pc update
   assert property (@(posedge clk) disable iff (rst)
      regwrite |-> !(pcen || (|irwrite)));

endmodule

// ==== logic/controller.sv ====
// Multicycle controller FSM that decodes opcodes and runs the four-phase memory handshake
`timescale 1ns/1ps

module controller (
   input  logic                  clk,
   input  logic                  rst,
   input  cpu_pkg::opcode_t      opcode,
   input  logic [5:0]            funct,
   input  logic                  zero,
   mem_bus_if.core               bus,
   output logic                  iord,
   output logic                  alusrca,
   output logic [1:0]            alusrcb,
   output logic [1:0]            pcsource,
   output logic                  memtoreg,
   output logic                  regdst,
   output logic [3:0]            irwrite,
   output logic                  pcen,
   output logic                  regwrite,
   output cpu_pkg::alu_op_t      alucont,
   output logic                  halted
);
   import cpu_pkg::*;

   // Memory access phases: idle, req up waiting for ack, ack seen waiting for ack low
   typedef enum logic [1:0] {ph_idle, ph_wait, ph_drop} phase_t;

   ctrl_state_t state;
   ctrl_state_t state_next;
   phase_t      phase;
   alu_op_t     funct_op;
   logic        mem_state;
   logic        ack_edge;
   logic        access_done;

   assign mem_state   = state inside {fetch1, fetch2, fetch3, fetch4, memrd, memwr};
   assign ack_edge    = (phase == ph_wait) && bus.ack;
   assign access_done = (phase == ph_drop) && !bus.ack;

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= fetch1;
         phase   <= ph_idle;
         bus.req <= 1'b0;
      end else begin
         state <= state_next;
         case (phase)
            ph_idle: begin
               if (mem_state && !bus.ack) begin
                  bus.req <= 1'b1;
                  phase   <= ph_wait;
               end
            end
            ph_wait: begin
               if (bus.ack) begin
                  bus.req <= 1'b0;
                  phase   <= ph_drop;
               end
            end
            default: begin
               if (!bus.ack) begin
                  phase <= ph_idle;
               end
            end
         endcase
      end
   end

   assign bus.we = (state == memwr);
   assign halted = (state == halt_st);

   always_comb begin
      state_next = state;
      case (state)
         fetch1:   if (access_done) state_next = fetch2;
         fetch2:   if (access_done) state_next = fetch3;
         fetch3:   if (access_done) state_next = fetch4;
         fetch4:   if (access_done) state_next = decode;
         decode: begin
            case (opcode)
               op_lb, op_sb, op_addi: state_next = memadr;
               op_rtype:              state_next = rtype_ex;
               op_beq:                state_next = beq_ex;
               op_j:                  state_next = j_ex;
               op_halt:               state_next = halt_st;
               // Unknown opcode is skipped
               default:               state_next = fetch1;
            endcase
         end
         memadr: begin
            case (opcode)
               op_lb:   state_next = memrd;
               op_sb:   state_next = memwr;
               default: state_next = addi_wb;
            endcase
         end
         memrd:    if (access_done) state_next = memwb;
         memwr:    if (access_done) state_next = fetch1;
         rtype_ex: state_next = rtype_wb;
         halt_st:  state_next = halt_st;
         default:  state_next = fetch1;
      endcase
   end

   always_comb begin
      case (funct)
         funct_sub: funct_op = alu_sub;
         funct_and: funct_op = alu_and;
         funct_or:  funct_op = alu_or;
         funct_slt: funct_op = alu_slt;
         default:   funct_op = alu_add;
      endcase
   end

   always_comb begin
      iord     = 1'b0;
      alusrca  = 1'b0;
      alusrcb  = src_b_one;
      pcsource = pc_from_alu;
      memtoreg = 1'b0;
      regdst   = 1'b0;
      irwrite  = 4'b0000;
      pcen     = 1'b0;
      regwrite = 1'b0;
      alucont  = alu_add;
      case (state)
         // Byte captured on ack, pc bumped once the access closes
         fetch1: begin irwrite[0] = ack_edge; pcen = access_done; end
         fetch2: begin irwrite[1] = ack_edge; pcen = access_done; end
         fetch3: begin irwrite[2] = ack_edge; pcen = access_done; end
         fetch4: begin irwrite[3] = ack_edge; pcen = access_done; end
         // Branch target computed ahead of time
         decode:  alusrcb = src_b_imm4;
         memadr: begin
            alusrca = 1'b1;
            alusrcb = src_b_imm;
         end
         // Address recomputed each cycle so aluout holds during the access
         memrd, memwr: begin
            iord    = 1'b1;
            alusrca = 1'b1;
            alusrcb = src_b_imm;
         end
         memwb: begin
            memtoreg = 1'b1;
            regwrite = 1'b1;
         end
         rtype_ex: begin
            alusrca = 1'b1;
            alusrcb = src_b_reg;
            alucont = funct_op;
         end
         rtype_wb: begin
            regdst   = 1'b1;
            regwrite = 1'b1;
         end
         addi_wb:  regwrite = 1'b1;
         beq_ex: begin
            alusrca  = 1'b1;
            alusrcb  = src_b_reg;
            alucont  = alu_sub;
            pcsource = pc_from_aluout;
            pcen     = zero;
         end
         j_ex: begin
            pcsource = pc_from_jump;
            pcen     = 1'b1;
         end
         default: ;
      endcase
   end

   // A new request waits until the memory has dropped ack
   assert property (@(posedge clk) disable iff (rst) $rose(bus.req) |-> !bus.ack);

endmodule

// ==== logic/byte_memory.sv ====
// 256-byte memory on the four-phase bus, loaded under reset and reporting every write
`timescale 1ns/1ps

module byte_memory (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           load_we,
   input  logic [cpu_pkg::data_width-1:0] load_adr,
   input  logic [cpu_pkg::data_width-1:0] load_data,
   mem_bus_if.mem                         bus,
   output logic                           store_valid,
   output logic [cpu_pkg::data_width-1:0] store_adr,
   output logic [cpu_pkg::data_width-1:0] store_data
);
   import cpu_pkg::*;

   logic [data_width-1:0]        mem [1 << data_width];
   logic [$clog2(mem_wait+1)-1:0] cnt;
   logic                          respond;
   logic                          write_now;

   // Answer after the wait count on a pending request
   assign respond   = !rst && bus.req && !bus.ack && (cnt == ($bits(cnt))'(mem_wait - 1));
   assign write_now = respond && bus.we;

   always_ff @(posedge clk) begin
      if (rst) begin
         bus.ack <= 1'b0;
         cnt     <= '0;
      end else if (bus.req && !bus.ack) begin
         if (respond) begin
            bus.ack <= 1'b1;
            cnt     <= '0;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end else if (!bus.req && bus.ack) begin
         bus.ack <= 1'b0;
      end
   end

   // Loader only while reset is held
   always_ff @(posedge clk) begin
      if (rst && load_we) begin
         mem[load_adr] <= load_data;
      end else if (write_now) begin
         mem[bus.adr] <= bus.wdata;
      end
   end

   // Read data held until the next read answer
   always_ff @(posedge clk) begin
      if (respond && !bus.we) begin
         bus.rdata <= mem[bus.adr];
      end
      if (write_now) begin
         store_adr  <= bus.adr;
         store_data <= bus.wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         store_valid <= 1'b0;
      end else begin
         store_valid <= write_now;
      end
   end

   assert property (@(posedge clk) disable iff (rst) $rose(bus.ack) |-> bus.req);

endmodule

// ==== logic/cpu_system.sv ====
// Top level joining controller, datapath and byte memory, with load and store ports
`timescale 1ns/1ps

module cpu_system (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           load_we,
   input  logic [cpu_pkg::data_width-1:0] load_adr,
   input  logic [cpu_pkg::data_width-1:0] load_data,
   output logic                           store_valid,
   output logic [cpu_pkg::data_width-1:0] store_adr,
   output logic [cpu_pkg::data_width-1:0] store_data,
   output logic                           halted
);
   import cpu_pkg::*;

   logic       iord;
   logic       alusrca;
   logic       memtoreg;
   logic       regdst;
   logic       pcen;
   logic       regwrite;
   logic       zero;
   logic [1:0] alusrcb;
   logic [1:0] pcsource;
   logic [3:0] irwrite;
   logic [5:0] funct;
   alu_op_t    alucont;
   opcode_t    opcode;

   mem_bus_if bus ();

   controller controller_inst (
      .clk (clk), .rst (rst), .opcode (opcode), .funct (funct), .zero (zero), .bus (bus),
      .iord (iord), .alusrca (alusrca), .alusrcb (alusrcb), .pcsource (pcsource),
      .memtoreg (memtoreg), .regdst (regdst), .irwrite (irwrite), .pcen (pcen),
      .regwrite (regwrite), .alucont (alucont), .halted (halted)
   );

   datapath datapath_inst (
      .clk (clk), .rst (rst), .iord (iord), .alusrca (alusrca), .alusrcb (alusrcb),
      .pcsource (pcsource), .memtoreg (memtoreg), .regdst (regdst), .irwrite (irwrite),
      .pcen (pcen), .regwrite (regwrite), .alucont (alucont), .bus (bus),
      .opcode (opcode), .funct (funct), .zero (zero)
   );

   byte_memory byte_memory_inst (
      .clk (clk), .rst (rst), .load_we (load_we), .load_adr (load_adr),
      .load_data (load_data), .bus (bus), .store_valid (store_valid),
      .store_adr (store_adr), .store_data (store_data)
   );

endmodule

// ==== testbench/store_checker.sv ====
// Watches the store port and halted of the processor and compares them with the current test
`timescale 1ns/1ps

module store_checker (
   input  logic            clk,
   input  logic            rst,
   input  logic            store_valid,
   input  logic [7:0]      store_adr,
   input  logic [7:0]      store_data,
   input  logic            halted,
   input  logic [8*12-1:0] test_name,
   input  int              exp_count,
   input  logic [7:0]      exp_adr [4],
   input  logic [7:0]      exp_val [4],
   output int              errors,
   output int              checks
);

   int   seen;
   int   error_q = 0;
   int   check_q = 0;
   logic halt_seen;
   logic rst_d;

   assign errors = error_q;
   assign checks = check_q;

   always @(posedge clk) begin
      int bad;
      int done;
      bad   = 0;
      done  = 0;
      rst_d <= rst;
      if (rst) begin
         seen      <= 0;
         halt_seen <= 1'b0;
         // Outputs are settled one edge into reset
         if (rst_d) begin
            done++;
            if (store_valid || halted) begin
               $display("%0s: store_valid or halted is high while reset is held", test_name);
               bad++;
            end
         end
      end else begin
         if (store_valid) begin
            if (halt_seen || halted) begin
               $display("%0s: a store arrived after halted rose", test_name);
               bad++;
            end else if (seen >= exp_count) begin
               $display("%0s: unexpected extra store to address %h", test_name, store_adr);
               bad++;
            end else begin
               done += 2;
               if (store_adr !== exp_adr[seen]) begin
                  $display("FAILED %0s store %0d address: expected %h actual %h",
                           test_name, seen, exp_adr[seen], store_adr);
                  bad++;
               end
               if (store_data !== exp_val[seen]) begin
                  $display("FAILED %0s store %0d value: expected %h actual %h",
                           test_name, seen, exp_val[seen], store_data);
                  bad++;
               end
            end
            seen <= seen + 1;
         end
         // Store count is final once the processor halts
         if (halted && !halt_seen) begin
            halt_seen <= 1'b1;
            done++;
            if (seen != exp_count) begin
               $display("FAILED %0s store count: expected %0d actual %0d",
                        test_name, exp_count, seen);
               bad++;
            end
         end
         if (halt_seen && !halted) begin
            $display("%0s: halted dropped before the next reset", test_name);
            bad++;
         end
      end
      error_q <= error_q + bad;
      check_q <= check_q + done;
   end

endmodule

// ==== testbench/cpu_system_tb.sv ====
// Testbench for the processor: loads each program from a table, runs it to halt, checks stores
`timescale 1ns/1ps

module cpu_system_tb;
   import cpu_pkg::*;

   localparam int n_tests   = 5;
   localparam int max_instr = 12;

   logic            clk;
   logic            rst;
   logic            load_we;
   logic [7:0]      load_adr;
   logic [7:0]      load_data;
   logic            store_valid;
   logic [7:0]      store_adr;
   logic [7:0]      store_data;
   logic            halted;
   int              errors;
   int              checks;
   int              limit_cycles = 0;

   // Test table
   logic [8*12-1:0] name_tab [n_tests];
   logic [31:0]     prog_tab [n_tests][max_instr];
   int              len_tab [n_tests];
   logic [7:0]      data_adr_tab [n_tests];
   logic [7:0]      data_val_tab [n_tests];
   int              exp_count_tab [n_tests];
   logic [7:0]      exp_adr_tab [n_tests][4];
   logic [7:0]      exp_val_tab [n_tests][4];

   // Row currently under test, seen by the checker
   logic [8*12-1:0] cur_name;
   int              cur_count;
   logic [7:0]      cur_adr [4];
   logic [7:0]      cur_val [4];

   cpu_system cpu_system_inst (
      .clk         (clk),
      .rst         (rst),
      .load_we     (load_we),
      .load_adr    (load_adr),
      .load_data   (load_data),
      .store_valid (store_valid),
      .store_adr   (store_adr),
      .store_data  (store_data),
      .halted      (halted)
   );

   store_checker store_checker_inst (
      .clk         (clk),
      .rst         (rst),
      .store_valid (store_valid),
      .store_adr   (store_adr),
      .store_data  (store_data),
      .halted      (halted),
      .test_name   (cur_name),
      .exp_count   (cur_count),
      .exp_adr     (cur_adr),
      .exp_val     (cur_val),
      .errors      (errors),
      .checks      (checks)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Fields: rs [23:21], rt [18:16], rd [13:11], immediate in the low byte
   function automatic logic [31:0] rtype_word(input logic [2:0] rs, input logic [2:0] rt,
                                              input logic [2:0] rd, input logic [5:0] fn);
      return {op_rtype, 2'b00, rs, 2'b00, rt, 2'b00, rd, 5'b00000, fn};
   endfunction

   function automatic logic [31:0] imm_word(input opcode_t op, input logic [2:0] rs,
                                            input logic [2:0] rt, input logic [7:0] imm);
      return {op, 2'b00, rs, 2'b00, rt, 8'h00, imm};
   endfunction

   // Target byte address is index times four
   function automatic logic [31:0] jump_word(input logic [5:0] index);
      return {op_j, 20'h00000, index};
   endfunction

   function automatic logic [31:0] halt_word();
      return {op_halt, 26'h0000000};
   endfunction

   task automatic add_instr(input int t, input logic [31:0] word);
      prog_tab[t][len_tab[t]] = word;
      len_tab[t]++;
   endtask

   task automatic expect_store(input int t, input logic [7:0] adr, input logic [7:0] val);
      exp_adr_tab[t][exp_count_tab[t]] = adr;
      exp_val_tab[t][exp_count_tab[t]] = val;
      exp_count_tab[t]++;
   endtask

   task automatic build_table();
      logic [7:0] x;
      logic [7:0] y;
      logic [7:0] k;
      for (int t = 0; t < n_tests; t++) begin
         len_tab[t]       = 0;
         exp_count_tab[t] = 0;
         data_adr_tab[t]  = 8'hff;
         data_val_tab[t]  = 8'h00;
      end
      // Add, sub, and, or on random operands, 8-bit wrapping
      name_tab[0] = "rtype_arith";
      x = 8'($urandom);
      y = 8'($urandom);
      add_instr(0, imm_word(op_addi, 3'd0, 3'd1, x));
      add_instr(0, imm_word(op_addi, 3'd0, 3'd2, y));
      add_instr(0, rtype_word(3'd1, 3'd2, 3'd3, funct_add));
      add_instr(0, imm_word(op_sb, 3'd0, 3'd3, 8'h80));
      add_instr(0, rtype_word(3'd1, 3'd2, 3'd4, funct_sub));
      add_instr(0, imm_word(op_sb, 3'd0, 3'd4, 8'h81));
      add_instr(0, rtype_word(3'd1, 3'd2, 3'd5, funct_and));
      add_instr(0, imm_word(op_sb, 3'd0, 3'd5, 8'h82));
      add_instr(0, rtype_word(3'd1, 3'd2, 3'd6, funct_or));
      add_instr(0, imm_word(op_sb, 3'd0, 3'd6, 8'h83));
      add_instr(0, halt_word());
      expect_store(0, 8'h80, x + y);
      expect_store(0, 8'h81, x - y);
      expect_store(0, 8'h82, x & y);
      expect_store(0, 8'h83, x | y);
      // Signed compare: negative < positive, not the reverse, not equal
      name_tab[1] = "slt_signed";
      x = 8'($urandom) | 8'h80;
      y = 8'($urandom) & 8'h7f;
      add_instr(1, imm_word(op_addi, 3'd0, 3'd1, x));
      add_instr(1, imm_word(op_addi, 3'd0, 3'd2, y));
      add_instr(1, rtype_word(3'd1, 3'd2, 3'd3, funct_slt));
      add_instr(1, imm_word(op_sb, 3'd0, 3'd3, 8'h90));
      add_instr(1, rtype_word(3'd2, 3'd1, 3'd4, funct_slt));
      add_instr(1, imm_word(op_sb, 3'd0, 3'd4, 8'h91));
      add_instr(1, rtype_word(3'd2, 3'd2, 3'd5, funct_slt));
      add_instr(1, imm_word(op_sb, 3'd0, 3'd5, 8'h92));
      add_instr(1, halt_word());
      expect_store(1, 8'h90, 8'h01);
      expect_store(1, 8'h91, 8'h00);
      expect_store(1, 8'h92, 8'h00);
      // Taken beq skips the store at A0, not-taken beq runs the store at A2
      name_tab[2] = "beq_paths";
      x = 8'($urandom);
      add_instr(2, imm_word(op_addi, 3'd0, 3'd1, x));
      add_instr(2, imm_word(op_addi, 3'd0, 3'd2, x));
      add_instr(2, imm_word(op_beq, 3'd1, 3'd2, 8'h01));
      add_instr(2, imm_word(op_sb, 3'd0, 3'd1, 8'ha0));
      add_instr(2, imm_word(op_sb, 3'd0, 3'd2, 8'ha1));
      add_instr(2, imm_word(op_addi, 3'd0, 3'd3, x + 8'd1));
      add_instr(2, imm_word(op_beq, 3'd1, 3'd3, 8'h01));
      add_instr(2, imm_word(op_sb, 3'd0, 3'd3, 8'ha2));
      add_instr(2, halt_word());
      expect_store(2, 8'ha1, x);
      expect_store(2, 8'ha2, x + 8'd1);
      // Loaded byte plus immediate, then a write to r0 that must read back zero
      name_tab[3] = "load_r0";
      x = 8'($urandom);
      k = 8'($urandom);
      data_adr_tab[3] = 8'hc0;
      data_val_tab[3] = x;
      add_instr(3, imm_word(op_lb, 3'd0, 3'd1, 8'hc0));
      add_instr(3, imm_word(op_addi, 3'd1, 3'd2, k));
      add_instr(3, imm_word(op_sb, 3'd0, 3'd2, 8'hc1));
      add_instr(3, imm_word(op_addi, 3'd1, 3'd0, k));
      add_instr(3, imm_word(op_sb, 3'd0, 3'd0, 8'hc2));
      add_instr(3, halt_word());
      expect_store(3, 8'hc1, x + k);
      expect_store(3, 8'hc2, 8'h00);
      // Jump to instruction 3 leaves the store at E0 out
      name_tab[4] = "jump_halt";
      x = 8'($urandom);
      add_instr(4, imm_word(op_addi, 3'd0, 3'd1, x));
      add_instr(4, jump_word(6'd3));
      add_instr(4, imm_word(op_sb, 3'd0, 3'd1, 8'he0));
      add_instr(4, imm_word(op_sb, 3'd0, 3'd1, 8'he1));
      add_instr(4, halt_word());
      expect_store(4, 8'he1, x);
      for (int t = 0; t < n_tests; t++) begin
         limit_cycles += len_tab[t] * 40 + 200;
      end
   endtask

   task automatic load_byte(input logic [7:0] adr, input logic [7:0] data);
      @(posedge clk);
      load_we   <= 1'b1;
      load_adr  <= adr;
      load_data <= data;
   endtask

   task automatic run_row(input int t);
      @(posedge clk);
      rst <= 1'b1;
      repeat (16) @(posedge clk);
      cur_name  = name_tab[t];
      cur_count = exp_count_tab[t];
      for (int s = 0; s < 4; s++) begin
         cur_adr[s] = exp_adr_tab[t][s];
         cur_val[s] = exp_val_tab[t][s];
      end
      // Little-endian bytes per instruction word
      for (int i = 0; i < len_tab[t]; i++) begin
         for (int b = 0; b < 4; b++) begin
            load_byte(8'(4 * i + b), prog_tab[t][i][8*b +: 8]);
         end
      end
      load_byte(data_adr_tab[t], data_val_tab[t]);
      @(posedge clk);
      load_we <= 1'b0;
      rst     <= 1'b0;
      while (!halted) @(posedge clk);
      // Hold so a late store or a falling halted is seen
      repeat (12) @(posedge clk);
   endtask

   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("Watchdog: the run did not finish within %0d cycles", limit_cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      rst       = 1'b1;
      load_we   = 1'b0;
      load_adr  = 8'h00;
      load_data = 8'h00;
      cur_name  = "reset";
      cur_count = 0;
      for (int s = 0; s < 4; s++) begin
         cur_adr[s] = 8'h00;
         cur_val[s] = 8'h00;
      end
      void'($urandom(32'h2bee_710d));
      build_table();
      for (int t = 0; t < n_tests; t++) begin
         run_row(t);
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== src.f ====
logic/cpu_pkg.sv
logic/mem_bus_if.sv
logic/alu.sv
logic/regfile.sv
logic/datapath.sv
logic/controller.sv
logic/byte_memory.sv
logic/cpu_system.sv
testbench/store_checker.sv
testbench/cpu_system_tb.sv

// ==== Makefile ====
# Verilator build and run for the multicycle 8-bit processor testbench

TOP = cpu_system_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, pass if the pass message appears"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^ALL TESTS PASSED$$"

clean:
	rm -rf obj_dir
